/* logic/ro_pkg.sv */
package ro_pkg;

   localparam int LINE_WORDS = 16;   // 32-bit words per memory line
   localparam int LINE_BITS  = 512;

   // incoming read request
   typedef struct packed {
      logic [31:0] addr;
      logic [2:0]  arsize;
      logic [7:0]  arlen;
      logic [15:0] tag;
   } rd_req_t;

   typedef struct packed {
      logic [15:0] tag;
      logic [63:0] data;
      logic [7:0]  word_id;
      logic        last;
   } out_beat_t;

   // accepted request, word count already expanded
   typedef struct packed {
      logic [31:0] addr;
      logic [2:0]  arsize;
      logic [7:0]  n_words;
      logic [7:0]  thread;   // low bits only
      logic [15:0] tag;      // kept per thread for the output beats
   } dec_t;

   // one outstanding line read, indexed by read id
   typedef struct packed {
      logic [7:0]  thread;
      logic [15:0] valid_words;
      logic [2:0]  arsize;
      logic [7:0]  start_word_id;
   } mshr_t;

endpackage

/* logic/free_list.sv */
`timescale 1ns/1ns

module free_list #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 release_en,
   input  logic [LOG_DEPTH-1:0] release_idx,
   input  logic                 take_en,
   output logic [LOG_DEPTH-1:0] next_idx,
   output logic                 empty,
   output logic                 full
);

   localparam int DEPTH = 2**LOG_DEPTH;

   logic [LOG_DEPTH-1:0] slots [DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH:0]   count;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < DEPTH; i++) begin
            slots[i] <= LOG_DEPTH'(i);   // every index free once
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (LOG_DEPTH+1)'(DEPTH);
      end else begin
         if (release_en) begin
            slots[wr_ptr] <= release_idx;
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (take_en) rd_ptr <= rd_ptr + 1'b1;
         if (release_en && !take_en) count <= count + 1'b1;
         else if (take_en && !release_en) count <= count - 1'b1;
      end
   end

   assign next_idx = slots[rd_ptr];
   assign empty    = (count == '0);
   assign full     = (count == (LOG_DEPTH+1)'(DEPTH));

   // users of the list stay within its bounds
   assert property (@(posedge clk) disable iff (!rstn) !(take_en && empty));
   assert property (@(posedge clk) disable iff (!rstn) !(release_en && full));

endmodule

/* logic/ro_decode.sv */
`timescale 1ns/1ns

module ro_decode import ro_pkg::*; #(
   parameter int N_THREADS = 8
) (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         in_valid,
   output logic                         in_ready,
   input  rd_req_t                      in_req,
   input  logic                         exec_free,
   input  logic                         thread_release,
   input  logic [$clog2(N_THREADS)-1:0] release_thread,
   output logic                         dec_valid,
   output dec_t                         dec,
   output logic                         idle
);

   localparam int LOG_T = $clog2(N_THREADS);

   logic [LOG_T-1:0] thr_next;
   logic             thr_empty;
   logic [7:0]       n_elems;

   free_list #(
      .LOG_DEPTH(LOG_T)
   ) thread_list (
      .clk         (clk),
      .rstn        (rstn),
      .release_en  (thread_release),
      .release_idx (release_thread),
      .take_en     (dec_valid),
      .next_idx    (thr_next),
      .empty       (thr_empty),
      .full        (idle)      // all contexts back home
   );

   assign in_ready  = !thr_empty && exec_free;
   assign dec_valid = in_valid && in_ready;

   always_comb begin
      n_elems     = in_req.arlen + 8'd1;
      dec.addr    = in_req.addr;
      dec.arsize  = in_req.arsize;
      dec.n_words = (in_req.arsize == 3'd3) ? {n_elems[6:0], 1'b0} : n_elems;  // 8-byte = 2 words
      dec.thread  = 8'(thr_next);
      dec.tag     = in_req.tag;
   end

   // only aligned 4-byte or 8-byte elements, no element straddles a line
   assert property (@(posedge clk) disable iff (!rstn)
      dec_valid |-> (in_req.arsize == 3'd2 && in_req.addr[1:0] == 2'd0) ||
                    (in_req.arsize == 3'd3 && in_req.addr[2:0] == 3'd0));

endmodule

/* logic/ro_execute.sv */
`timescale 1ns/1ns

module ro_execute import ro_pkg::*; #(
   parameter int LOG_N_IDS = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 dec_valid,
   input  dec_t                 dec,
   output logic                 exec_free,
   output logic                 arvalid,
   input  logic                 arready,
   output logic [31:0]          araddr,
   output logic [LOG_N_IDS-1:0] arid,
   input  logic                 id_release,
   input  logic [LOG_N_IDS-1:0] release_id,
   output logic                 mshr_we,
   output logic [LOG_N_IDS-1:0] mshr_id,
   output mshr_t                mshr_entry
);

   logic        busy;
   logic [31:0] addr;
   logic [7:0]  words_left;
   logic [7:0]  thread;
   logic [2:0]  arsize;
   logic [7:0]  start_word_id;
   logic [3:0]  off;
   logic [7:0]  room;
   logic [7:0]  rd_words;
   logic        last_read;
   logic        ar_fire;
   logic        id_empty;

   free_list #(
      .LOG_DEPTH(LOG_N_IDS)
   ) id_list (
      .clk         (clk),
      .rstn        (rstn),
      .release_en  (id_release),
      .release_idx (release_id),
      .take_en     (ar_fire),
      .next_idx    (arid),
      .empty       (id_empty),
      .full        ()
   );

   assign off       = addr[5:2];                     // word offset in the line
   assign room      = 8'(LINE_WORDS) - 8'(off);
   assign last_read = (words_left <= room);
   assign rd_words  = last_read ? words_left : room;

   assign arvalid   = busy && !id_empty;             // hold off until an id is free
   assign ar_fire   = arvalid && arready;
   assign exec_free = !busy || (ar_fire && last_read);
   assign araddr    = addr;

   always_ff @(posedge clk) begin
      if (!rstn) busy <= 1'b0;
      else if (dec_valid) busy <= 1'b1;
      else if (ar_fire && last_read) busy <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (dec_valid) begin
         addr          <= dec.addr;
         words_left    <= dec.n_words;
         thread        <= dec.thread;
         arsize        <= dec.arsize;
         start_word_id <= '0;
      end else if (ar_fire && !last_read) begin
         addr       <= {addr[31:6] + 26'd1, 6'd0};   // next line base
         words_left <= words_left - rd_words;
         start_word_id <= start_word_id + ((arsize == 3'd3) ? (rd_words >> 1) : rd_words);
      end
   end

   always_comb begin
      mshr_entry.thread        = thread;
      mshr_entry.arsize        = arsize;
      mshr_entry.start_word_id = start_word_id;
      for (int i = 0; i < LINE_WORDS; i++) begin
         mshr_entry.valid_words[i] = (i >= int'(off)) && (i < int'(off) + int'(rd_words));
      end
   end

   assign mshr_we = ar_fire;
   assign mshr_id = arid;

   // address channel holds its request until taken
   assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid));

endmodule

/* logic/ro_result.sv */
`timescale 1ns/1ns

module ro_result import ro_pkg::*; #(
   parameter int N_THREADS = 8,
   parameter int LOG_N_IDS = 3
) (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         rvalid,
   output logic                         rready,
   input  logic [LOG_N_IDS-1:0]         rid,
   input  logic [LINE_BITS-1:0]         rdata,
   input  logic                         mshr_we,
   input  logic [LOG_N_IDS-1:0]         mshr_id,
   input  mshr_t                        mshr_entry,
   input  logic                         dec_valid,
   input  dec_t                         dec,
   output logic                         out_valid,
   input  logic                         out_ready,
   output out_beat_t                    out_beat,
   output logic                         id_release,
   output logic [LOG_N_IDS-1:0]         release_id,
   output logic                         thread_release,
   output logic [$clog2(N_THREADS)-1:0] release_thread
);

   localparam int LOG_T = $clog2(N_THREADS);

   typedef struct packed {
      logic [LOG_N_IDS-1:0] id;
      logic [LINE_BITS-1:0] data;
   } rd_entry_t;

   rd_entry_t  rd_fifo [4];
   rd_entry_t  head;
   logic [1:0] fifo_wr;
   logic [1:0] fifo_rd;
   logic [2:0] fifo_count;
   logic       fifo_push;
   logic       fifo_pop;

   mshr_t       mshr [2**LOG_N_IDS];
   logic [15:0] thr_tag [N_THREADS];
   logic [7:0]  thr_left [N_THREADS];   // words still owed to the thread

   logic                 cur_valid;
   logic [LINE_BITS-1:0] cur_data;
   logic [15:0]          cur_words;
   logic [2:0]           cur_arsize;
   logic [LOG_T-1:0]     cur_thread;
   logic [7:0]           cur_word_id;

   logic        pair;
   logic [3:0]  low;
   logic [3:0]  high;
   logic [7:0]  beat_words;
   logic [15:0] next_words;
   logic        beat_fire;
   logic        line_done;

   assign rready     = (fifo_count != 3'd4);
   assign fifo_push  = rvalid && rready;
   assign head       = rd_fifo[fifo_rd];
   assign line_done  = beat_fire && (next_words == '0);
   assign fifo_pop   = (fifo_count != 3'd0) && (!cur_valid || line_done);
   assign id_release = fifo_pop;
   assign release_id = head.id;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         fifo_wr    <= '0;
         fifo_rd    <= '0;
         fifo_count <= '0;
         cur_valid  <= 1'b0;
      end else begin
         if (fifo_push) fifo_wr <= fifo_wr + 1'b1;
         if (fifo_pop) fifo_rd <= fifo_rd + 1'b1;
         if (fifo_push && !fifo_pop) fifo_count <= fifo_count + 1'b1;
         else if (fifo_pop && !fifo_push) fifo_count <= fifo_count - 1'b1;
         if (fifo_pop) cur_valid <= 1'b1;
         else if (line_done) cur_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fifo_push) rd_fifo[fifo_wr] <= '{id: rid, data: rdata};
      if (mshr_we) mshr[mshr_id] <= mshr_entry;
      if (beat_fire) thr_left[cur_thread] <= thr_left[cur_thread] - beat_words;
      if (dec_valid) begin
         thr_tag[dec.thread[LOG_T-1:0]]  <= dec.tag;
         thr_left[dec.thread[LOG_T-1:0]] <= dec.n_words;
      end
      if (fifo_pop) begin
         cur_data    <= head.data;
         cur_words   <= mshr[head.id].valid_words;
         cur_arsize  <= mshr[head.id].arsize;
         cur_thread  <= mshr[head.id].thread[LOG_T-1:0];
         cur_word_id <= mshr[head.id].start_word_id;
      end else if (beat_fire) begin
         cur_words   <= next_words;
         cur_word_id <= cur_word_id + 8'd1;
      end
   end

   always_comb begin
      low = '0;
      for (int i = LINE_WORDS-1; i >= 0; i--) begin
         if (cur_words[i]) low = 4'(i);   // lowest wanted word wins
      end
      pair       = (cur_arsize == 3'd3);
      high       = low | 4'd1;            // pairs are 8-byte aligned
      beat_words = pair ? 8'd2 : 8'd1;
      next_words = cur_words;
      next_words[low] = 1'b0;
      if (pair) next_words[high] = 1'b0;
      out_beat.tag         = thr_tag[cur_thread];
      out_beat.data[31:0]  = cur_data[low*32 +: 32];
      out_beat.data[63:32] = pair ? cur_data[high*32 +: 32] : 32'd0;
      out_beat.word_id     = cur_word_id;
      out_beat.last        = (thr_left[cur_thread] == beat_words);
   end

   assign out_valid      = cur_valid;
   assign beat_fire      = out_valid && out_ready;
   assign thread_release = beat_fire && out_beat.last;
   assign release_thread = cur_thread;

   // output beat waits unchanged for the consumer
   assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

/* logic/ro_stage.sv */
`timescale 1ns/1ns

module ro_stage import ro_pkg::*; #(
   parameter int N_THREADS = 8,
   parameter int LOG_N_IDS = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  rd_req_t              in_req,
   output logic                 arvalid,
   input  logic                 arready,
   output logic [31:0]          araddr,
   output logic [LOG_N_IDS-1:0] arid,
   input  logic                 rvalid,
   output logic                 rready,
   input  logic [LOG_N_IDS-1:0] rid,
   input  logic [LINE_BITS-1:0] rdata,
   output logic                 out_valid,
   input  logic                 out_ready,
   output out_beat_t            out_beat,
   output logic                 idle
);

   logic                         dec_valid;
   dec_t                         dec;
   logic                         exec_free;
   logic                         mshr_we;
   logic [LOG_N_IDS-1:0]         mshr_id;
   mshr_t                        mshr_entry;
   logic                         thread_release;
   logic [$clog2(N_THREADS)-1:0] release_thread;
   logic                         id_release;
   logic [LOG_N_IDS-1:0]         release_id;

   // port names line up across the three blocks
   ro_decode #(.N_THREADS(N_THREADS)) decode_inst (.*);

   ro_execute #(.LOG_N_IDS(LOG_N_IDS)) execute_inst (.*);

   ro_result #(
      .N_THREADS (N_THREADS),
      .LOG_N_IDS (LOG_N_IDS)
   ) result_inst (.*);

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   initial begin
      rstn = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2 rstn = 1'b1;   // same offset as the other inputs
   end

endmodule

/* bench/tb_check.sv */
`timescale 1ns/1ns

module tb_check import ro_pkg::*; #(
   parameter int          N_THREADS   = 8,
   parameter int          LOG_N_IDS   = 3,
   parameter int          N_REQS      = 200,
   parameter logic [31:0] MEM_PATTERN = 32'h0
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 in_valid,
   input  logic                 in_ready,
   input  rd_req_t              in_req,
   input  logic                 arvalid,
   input  logic                 arready,
   input  logic [31:0]          araddr,
   input  logic [LOG_N_IDS-1:0] arid,
   input  logic                 rvalid,
   input  logic                 rready,
   input  logic [LOG_N_IDS-1:0] rid,
   input  logic                 out_valid,
   input  logic                 out_ready,
   input  out_beat_t            out_beat,
   input  logic                 idle,
   output int                   errors,
   output int                   outstanding
);

   localparam int N_TESTS = 6;
   localparam int T_SZ4   = 0;
   localparam int T_SZ8   = 1;
   localparam int T_COVER = 2;
   localparam int T_SPLIT = 3;
   localparam int T_LIMIT = 4;
   localparam int T_IDLE  = 5;

   string names [N_TESTS] = '{"size4_data", "size8_data", "word_cover",
                              "read_split", "thread_limit", "idle_level"};
   int    checks [N_TESTS] = '{default: 0};
   int    errs [N_TESTS]   = '{default: 0};
   int    err_total  = 0;
   int    live_count = 0;   // accepted, last beat not yet seen

   logic [31:0] req_addr [N_REQS];
   logic [2:0]  req_size [N_REQS];
   int          req_len [N_REQS];
   int          req_beats [N_REQS];
   logic [15:0] req_seen [N_REQS];
   bit          req_live [N_REQS];
   int          ar_tags [$];          // requests still owed address reads, in order
   bit          ar_first = 1'b1;
   int          ar_left;
   logic [31:0] ar_next;
   bit          id_busy [2**LOG_N_IDS];

   assign errors      = err_total;
   assign outstanding = live_count;

   function automatic logic [31:0] model_word(logic [31:0] a);
      return a ^ MEM_PATTERN;
   endfunction

   task automatic check_eq(int t, logic [63:0] exp, logic [63:0] act);
      checks[t]++;
      if (exp !== act) begin
         errs[t]++;
         err_total++;
         $display("ERR %s expected %0h actual %0h", names[t], exp, act);
      end
   endtask

   task automatic report_problem(int t, string what);
      checks[t]++;
      errs[t]++;
      err_total++;
      $display("%s: %s", names[t], what);
   endtask

   task automatic watch_accept();
      int tag;
      tag = int'(in_req.tag);
      if (tag >= N_REQS) begin
         report_problem(T_COVER, "accepted a request with an unexpected tag");
      end else begin
         req_addr[tag]  = in_req.addr;
         req_size[tag]  = in_req.arsize;
         req_len[tag]   = int'(in_req.arlen);
         req_beats[tag] = 0;
         req_seen[tag]  = '0;
         req_live[tag]  = 1'b1;
         ar_tags.push_back(tag);
         live_count++;
      end
   endtask

   task automatic watch_read_addr();
      int          tag;
      int          room;
      logic [31:0] exp;
      if (ar_tags.size() == 0) begin
         report_problem(T_SPLIT, "read address issued with no request waiting");
      end else begin
         tag = ar_tags[0];
         if (ar_first) begin
            exp = req_addr[tag];
            ar_left = (req_size[tag] == 3'd3) ? 2 * (req_len[tag] + 1) : req_len[tag] + 1;
         end else begin
            exp = ar_next;
            check_eq(T_SPLIT, 64'(0), 64'(araddr[5:0]));   // later reads start on a line
         end
         check_eq(T_SPLIT, 64'(exp), 64'(araddr));
         check_eq(T_SPLIT, 64'(0), 64'(id_busy[arid]));
         room = 16 - int'(exp[5:2]);
         ar_left -= (ar_left < room) ? ar_left : room;
         ar_next = (exp | 32'h3f) + 32'd1;
         ar_first = (ar_left == 0);
         if (ar_left == 0) void'(ar_tags.pop_front());
      end
   endtask

   task automatic watch_beat();
      int          tag;
      int          k;
      logic [31:0] a;
      tag = int'(out_beat.tag);
      k   = int'(out_beat.word_id);
      if (tag >= N_REQS || !req_live[tag]) begin
         report_problem(T_COVER, "beat arrived for a tag with no live request");
      end else if (k > req_len[tag]) begin
         check_eq(T_COVER, 64'(req_len[tag]), 64'(k));
      end else begin
         a = req_addr[tag];
         check_eq(T_COVER, 64'(0), 64'(req_seen[tag][k]));
         req_seen[tag][k] = 1'b1;
         if (req_size[tag] == 3'd3) begin
            check_eq(T_SZ8, {model_word(a + 32'(8*k) + 32'd4), model_word(a + 32'(8*k))},
                     out_beat.data);
         end else begin
            check_eq(T_SZ4, 64'(model_word(a + 32'(4*k))), 64'(out_beat.data[31:0]));
         end
         req_beats[tag]++;
         check_eq(T_COVER, 64'(req_beats[tag] == req_len[tag] + 1), 64'(out_beat.last));
         if (req_beats[tag] == req_len[tag] + 1) begin
            req_live[tag] = 1'b0;
            live_count--;
         end
      end
   endtask

   // everything is stable at the falling edge, handshakes land on the next rise
   always @(negedge clk) begin
      if (rstn) begin
         if (live_count == N_THREADS) check_eq(T_LIMIT, 64'(0), 64'(in_ready));
         check_eq(T_IDLE, 64'(live_count == 0), 64'(idle));
         if (live_count == 0 && ar_tags.size() != 0) begin
            report_problem(T_SPLIT, "finished request was still owed address reads");
            ar_tags.delete();
            ar_first = 1'b1;
         end
         if (arvalid && arready) watch_read_addr();
         if (rvalid && rready) id_busy[rid] = 1'b0;
         if (arvalid && arready) id_busy[arid] = 1'b1;
         if (out_valid && out_ready) watch_beat();
         if (in_valid && in_ready) watch_accept();
      end
   end

   task automatic summarize();
      int total;
      total = 0;
      for (int t = 0; t < N_TESTS; t++) begin
         $display("%-12s %0d checks, %0d errors", names[t], checks[t], errs[t]);
         total += checks[t];
      end
      $display("total %0d checks, %0d errors", total, err_total);
   endtask

endmodule

/* bench/tb_top.sv */
`timescale 1ns/1ns

module tb_top import ro_pkg::*;;

   localparam int          N_THREADS      = 8;
   localparam int          LOG_N_IDS      = 3;
   localparam int          N_REQS         = 200;
   localparam logic [31:0] SEED           = 32'h4d64_a16c;
   localparam logic [31:0] MEM_PATTERN    = 32'h5a3c_96e1;
   localparam int          RESET_TIMEOUT  = 20;
   localparam int          REQ_TIMEOUT    = 2000;
   localparam int          DRAIN_TIMEOUT  = 5000;

   logic                 clk;
   logic                 rstn;
   logic                 in_valid;
   logic                 in_ready;
   rd_req_t              in_req;
   logic                 arvalid;
   logic                 arready;
   logic [31:0]          araddr;
   logic [LOG_N_IDS-1:0] arid;
   logic                 rvalid;
   logic                 rready;
   logic [LOG_N_IDS-1:0] rid;
   logic [LINE_BITS-1:0] rdata;
   logic                 out_valid;
   logic                 out_ready;
   out_beat_t            out_beat;
   logic                 idle;
   int                   errors;
   int                   outstanding;

   rd_req_t              reqs [N_REQS];
   int                   gaps [N_REQS];
   logic [31:0]          pend_addr [$];   // reads taken by the memory, not yet answered
   logic [LOG_N_IDS-1:0] pend_id [$];
   int                   pend_due [$];

   tb_clock #(.PERIOD(40), .RESET_CYCLES(3)) clock_inst (.clk(clk), .rstn(rstn));

   ro_stage #(.N_THREADS(N_THREADS), .LOG_N_IDS(LOG_N_IDS)) ro_stage_inst (.*);

   tb_check #(
      .N_THREADS   (N_THREADS),
      .LOG_N_IDS   (LOG_N_IDS),
      .N_REQS      (N_REQS),
      .MEM_PATTERN (MEM_PATTERN)
   ) check_inst (.*);

   function automatic logic [LINE_BITS-1:0] line_data(logic [31:0] a);
      logic [LINE_BITS-1:0] line;
      logic [31:0]          base;
      base = {a[31:6], 6'd0};
      for (int i = 0; i < LINE_WORDS; i++) begin
         line[i*32 +: 32] = (base + 32'(4*i)) ^ MEM_PATTERN;
      end
      return line;
   endfunction

   task automatic make_requests();
      logic [31:0] a;
      logic [2:0]  size;
      for (int n = 0; n < N_REQS; n++) begin
         size = ($urandom % 2 == 0) ? 3'd2 : 3'd3;
         a = $urandom;
         a[1:0] = 2'b00;
         if (size == 3'd3) a[2] = 1'b0;   // 8-byte elements stay 8-byte aligned
         reqs[n].addr   = a;
         reqs[n].arsize = size;
         reqs[n].arlen  = 8'($urandom % 16);
         reqs[n].tag    = 16'(n);
         gaps[n] = int'($urandom % 4);
      end
   endtask

   // memory side and output back-pressure, one step per clock
   task automatic serve_memory();
      bit                   ar_hs;
      bit                   r_hs;
      logic [31:0]          ar_a;
      logic [LOG_N_IDS-1:0] ar_i;
      int                   idx;
      int                   cycle;
      cycle = 0;
      forever begin
         @(negedge clk);
         ar_hs = arvalid && arready;
         r_hs  = rvalid && rready;
         ar_a  = araddr;
         ar_i  = arid;
         @(posedge clk);
         #2;
         cycle++;
         if (ar_hs) begin
            pend_addr.push_back(ar_a);
            pend_id.push_back(ar_i);
            pend_due.push_back(cycle + int'($urandom_range(1, 12)));
         end
         if (r_hs) rvalid = 1'b0;
         if (!rvalid && pend_addr.size() > 0) begin
            idx = int'($urandom % 32'(pend_addr.size()));   // any queued read may go first
            if (pend_due[idx] <= cycle) begin
               rvalid = 1'b1;
               rid    = pend_id[idx];
               rdata  = line_data(pend_addr[idx]);
               pend_addr.delete(idx);
               pend_id.delete(idx);
               pend_due.delete(idx);
            end
         end
         arready   = ($urandom % 4) != 0;
         out_ready = ($urandom % 3) != 0;
      end
   endtask

   task automatic run_traffic(output bit ok);
      int waited;
      bit took;
      ok = 1'b0;
      waited = 0;
      while (!rstn) begin
         @(posedge clk);
         waited++;
         if (waited > RESET_TIMEOUT) begin
            $display("reset was never released");
            return;
         end
      end
      @(posedge clk);
      #2;
      for (int n = 0; n < N_REQS; n++) begin
         repeat (gaps[n]) begin
            @(posedge clk);
            #2;
         end
         in_valid = 1'b1;
         in_req   = reqs[n];
         waited = 0;
         took   = 1'b0;
         while (!took && waited < REQ_TIMEOUT) begin
            @(negedge clk);
            took = in_ready;
            @(posedge clk);
            #2;
            waited++;
         end
         in_valid = 1'b0;
         if (!took) begin
            $display("request %0d was not accepted in time", n);
            return;
         end
      end
      waited = 0;
      while (outstanding != 0 || !idle) begin
         @(posedge clk);
         #2;
         waited++;
         if (waited > DRAIN_TIMEOUT) begin
            $display("outstanding requests did not drain in time");
            return;
         end
      end
      repeat (4) begin
         @(posedge clk);
         #2;
      end
      ok = 1'b1;
   endtask

   initial begin
      bit ok;
      in_valid  = 1'b0;
      in_req    = '0;
      arready   = 1'b0;
      rvalid    = 1'b0;
      rid       = '0;
      rdata     = '0;
      out_ready = 1'b0;
      void'($urandom(SEED));
      make_requests();
      fork
         serve_memory();
      join_none
      run_traffic(ok);
      check_inst.summarize();
      if (ok && errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* tb.f */
logic/ro_pkg.sv
logic/free_list.sv
logic/ro_decode.sv
logic/ro_execute.sv
logic/ro_result.sv
logic/ro_stage.sv
bench/tb_clock.sv
bench/tb_check.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns -f tb.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Regression passed" "$LOG"; then
   exit 0
fi
exit 1
